//--- files.f
verilog/pad_ctrl_pkg.sv
verilog/reset_sequencer.sv
verilog/watchdog_timer.sv
verilog/pad_cfg_regs.sv
verilog/pad_mux.sv
verilog/pad_ctrl_top.sv
verification/pad_ctrl_assert.sv
verification/tb_pad_ctrl.sv

//--- Bender.yml
package:
  name: pad_ctrl

sources:
  - verilog/pad_ctrl_pkg.sv
  - verilog/reset_sequencer.sv
  - verilog/watchdog_timer.sv
  - verilog/pad_cfg_regs.sv
  - verilog/pad_mux.sv
  - verilog/pad_ctrl_top.sv
  - target: test
    files:
      - verification/pad_ctrl_assert.sv
      - verification/tb_pad_ctrl.sv

//--- verification/pad_ctrl_cases.txt
# name op a d e, values in hex; write: addr data, pad: pad sel cfg, src: source - mask
# kick: count interval expired, expire: bootsel reload low_cycles, boot: - - bootsel
rst_boot   boot   0 0    1
wr_pad0    write  0 0015 0
wr_pad1    write  1 006a 0
wr_pad2    write  2 00bf 0
wr_pad3    write  3 00c1 0
wr_pad5    write  5 0051 0
wr_pad6    write  6 00a2 0
chk_pad0   pad    0 0    15
chk_pad1   pad    1 1    2a
chk_pad2   pad    2 2    3f
chk_pad3   pad    3 3    01
chk_pad6   pad    6 2    22
src_perio  src    0 0    01
src_apbio  src    1 0    22
src_fpga   src    2 0    44
wr_ignore  write  c ffff 0
chk_keep1  pad    1 1    2a
chk_keep4  pad    4 3    00
wd_load    write  8 0014 0
wd_kick    kick   6 a    0
wd_load2   write  8 0010 0
wd_expire  expire 0 10   4
wd_boot    boot   0 0    0
post_pad1  pad    1 3    00
post_pad2  pad    2 3    00
post_src   src    1 0    00

//--- verification/tb_pad_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pad_ctrl;

  localparam int CLK_HALF = 10;
  localparam int N        = pad_ctrl_pkg::N_PADS;

  logic                                       io;
  logic                                       arst_n_i;
  logic                                       bootsel_i;
  logic                                       cfg_we_i;
  logic [pad_ctrl_pkg::ADDR_W-1:0]            cfg_addr_i;
  logic [pad_ctrl_pkg::WORD_W-1:0]            cfg_wdata_i;
  logic                                       wd_kick_i;
  logic [N-1:0]                               pad_in_i;
  logic [N-1:0]                               perio_out_i;
  logic [N-1:0]                               perio_oe_i;
  logic [N-1:0]                               apbio_out_i;
  logic [N-1:0]                               apbio_oe_i;
  logic [N-1:0]                               fpgaio_out_i;
  logic [N-1:0]                               fpgaio_oe_i;
  logic [N-1:0]                               pad_out_o;
  logic [N-1:0]                               pad_oe_o;
  logic [N-1:0][pad_ctrl_pkg::PADCFG_W-1:0]   pad_cfg_o;
  logic [N-1:0]                               perio_in_o;
  logic [N-1:0]                               apbio_in_o;
  logic [N-1:0]                               fpgaio_in_o;
  logic                                       soc_rst_n_o;
  logic                                       bootsel_o;
  logic                                       wd_expired_o;

  logic [31:0] lfsr_state;
  int          fd;
  int          n_cases;
  int          release_cycles;

  pad_ctrl_top pad_ctrl_top_i (.*);

  initial io = 1'b0;
  always #(CLK_HALF) io = ~io;

  // Right shifting Galois LFSR
  function automatic logic next_lfsr_bit();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [N-1:0] random_vector();
    logic [N-1:0] v;
    for (int i = 0; i < N; i++) begin
      v[i] = next_lfsr_bit();
    end
    return v;
  endfunction

  task automatic randomize_sources();
    pad_in_i     = random_vector();
    perio_out_i  = random_vector();
    perio_oe_i   = random_vector();
    apbio_out_i  = random_vector();
    apbio_oe_i   = random_vector();
    fpgaio_out_i = random_vector();
    fpgaio_oe_i  = random_vector();
  endtask

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %0h actual %0h", test, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic write_cfg(input logic [31:0] addr, input logic [31:0] data);
    @(negedge io);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr[pad_ctrl_pkg::ADDR_W-1:0];
    cfg_wdata_i = data[pad_ctrl_pkg::WORD_W-1:0];
    @(negedge io);
    cfg_we_i = 1'b0;
  endtask

  task automatic check_pad(input string test, input logic [31:0] pad,
                           input logic [31:0] sel, input logic [31:0] cfg);
    logic [pad_ctrl_pkg::IDX_W-1:0] idx;
    logic [1:0]                     exp_bits;
    idx = pad[pad_ctrl_pkg::IDX_W-1:0];
    @(negedge io);
    randomize_sources();
    #(CLK_HALF / 2);
    // Expected {out, oe} of the selected source
    case (sel[pad_ctrl_pkg::MUX_W-1:0])
      pad_ctrl_pkg::SEL_PERIO:  exp_bits = {perio_out_i[idx], perio_oe_i[idx]};
      pad_ctrl_pkg::SEL_APBIO:  exp_bits = {apbio_out_i[idx], apbio_oe_i[idx]};
      pad_ctrl_pkg::SEL_FPGAIO: exp_bits = {fpgaio_out_i[idx], fpgaio_oe_i[idx]};
      default:                  exp_bits = 2'b00;
    endcase
    check_value(test, cfg, pad_cfg_o[idx]);
    check_value(test, exp_bits, {pad_out_o[idx], pad_oe_o[idx]});
  endtask

  task automatic check_source(input string test, input logic [31:0] src,
                              input logic [31:0] mask);
    logic [N-1:0] actual;
    @(negedge io);
    randomize_sources();
    #(CLK_HALF / 2);
    case (src)
      0:       actual = perio_in_o;
      1:       actual = apbio_in_o;
      default: actual = fpgaio_in_o;
    endcase
    check_value(test, pad_in_i & mask[N-1:0], actual);
  endtask

  task automatic kick_watchdog(input string test, input logic [31:0] count,
                               input logic [31:0] interval, input logic [31:0] expired);
    for (int k = 0; k < count; k++) begin
      for (int c = 0; c < interval; c++) begin
        @(negedge io);
        check_value(test, expired, wd_expired_o);
      end
      wd_kick_i = 1'b1;
      @(negedge io);
      wd_kick_i = 1'b0;
      check_value(test, expired, wd_expired_o);
    end
  endtask

  task automatic wait_expiry(input string test, input logic [31:0] boot,
                             input logic [31:0] reload, input logic [31:0] low_exp);
    int cycles;
    int low_cycles;
    @(negedge io);
    bootsel_i = boot[0];
    cycles    = 0;
    while (wd_expired_o !== 1'b1) begin
      if (cycles > reload + 2) begin
        $display("Timeout: watchdog did not expire in test %s", test);
        stop_on_failure();
      end
      @(negedge io);
      cycles++;
    end
    @(negedge io);
    check_value(test, 0, wd_expired_o);
    low_cycles = 0;
    while (soc_rst_n_o !== 1'b1) begin
      if (low_cycles > low_exp + 4) begin
        $display("Timeout: soc reset stayed low in test %s", test);
        stop_on_failure();
      end
      @(negedge io);
      low_cycles++;
    end
    check_value(test, low_exp, low_cycles);
  endtask

  task automatic run_case(input string test, input string op, input logic [31:0] a,
                          input logic [31:0] d, input logic [31:0] e);
    case (op)
      "write":  write_cfg(a, d);
      "pad":    check_pad(test, a, d, e);
      "src":    check_source(test, a, e);
      "kick":   kick_watchdog(test, a, d, e);
      "expire": wait_expiry(test, a, d, e);
      "boot": begin
        @(negedge io);
        check_value(test, e, bootsel_o);
      end
      default: begin
        $display("Case %s has an unknown opcode %s", test, op);
        stop_on_failure();
      end
    endcase
  endtask

  task automatic read_cases(input int file);
    string       line;
    string       test;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    int          fields;
    while (!$feof(file)) begin
      line = "";
      void'($fgets(line, file));
      if (line.len() > 0 && line[0] != "#") begin
        fields = $sscanf(line, "%s %s %h %h %h", test, op, a, d, e);
        if (fields == 5) begin
          run_case(test, op, a, d, e);
          n_cases++;
        end else if (fields > 0) begin
          $display("Malformed line in the case file: %s", line);
          stop_on_failure();
        end
      end
    end
  endtask

  initial begin
    lfsr_state  = 32'h377f_3f41;
    arst_n_i    = 1'b0;
    bootsel_i   = 1'b1;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    wd_kick_i   = 1'b0;
    n_cases     = 0;
    randomize_sources();
    repeat (4) @(negedge io);
    arst_n_i       = 1'b1;
    release_cycles = 0;
    while (soc_rst_n_o !== 1'b1) begin
      if (release_cycles > 2 * pad_ctrl_pkg::RST_HOLD) begin
        $display("Timeout: soc reset was not released after arst_n_i rose");
        stop_on_failure();
      end
      @(negedge io);
      release_cycles++;
    end
    check_value("reset_release", pad_ctrl_pkg::RST_HOLD, release_cycles);
    check_value("reset_oe", 0, pad_oe_o);
    check_value("reset_cfg", {pad_ctrl_pkg::N_PADS{pad_ctrl_pkg::PADCFG_DEFAULT}}, pad_cfg_o);
    check_value("reset_src", 0, {perio_in_o, apbio_in_o, fpgaio_in_o});
    check_value("reset_expired", 0, wd_expired_o);
    fd = $fopen("verification/pad_ctrl_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file");
      stop_on_failure();
    end else begin
      read_cases(fd);
      $fclose(fd);
      if (n_cases == 0) begin
        $display("No cases were read from the case file");
        stop_on_failure();
      end else begin
        $display("PASS: all tests");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/pad_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pad_ctrl_assert (
  input wire                              io,
  input wire                              arst_n_i,
  input wire                              soc_rst_n_i,
  input wire                              wd_expired_i,
  input wire [pad_ctrl_pkg::N_PADS-1:0]   pad_oe_i
);

  // Expiry is a single-cycle pulse
  expired_pulse_a : assert property (@(posedge io) disable iff (!arst_n_i)
    wd_expired_i |=> !wd_expired_i)
    else $error("wd_expired_o stayed high for more than one cycle");

  // Soc reset drops right after the pulse
  expired_reset_a : assert property (@(posedge io) disable iff (!arst_n_i)
    wd_expired_i |=> $fell(soc_rst_n_i))
    else $error("soc_rst_n_o did not fall on the edge after wd_expired_o");

  // No pad driven while the soc is held
  reset_oe_a : assert property (@(posedge io) disable iff (!arst_n_i)
    !soc_rst_n_i |-> (pad_oe_i == '0))
    else $error("pad_oe_o is active while soc_rst_n_o is low");

endmodule

bind pad_ctrl_top pad_ctrl_assert pad_ctrl_assert_i (
  .io           (io),
  .arst_n_i     (arst_n_i),
  .soc_rst_n_i  (soc_rst_n_o),
  .wd_expired_i (wd_expired_o),
  .pad_oe_i     (pad_oe_o)
);

`default_nettype wire

//--- verilog/pad_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pad_ctrl_top (
  input  wire                                                         io,
  input  wire                                                         arst_n_i,
  input  wire                                                         bootsel_i,
  input  wire                                                         cfg_we_i,
  input  wire [pad_ctrl_pkg::ADDR_W-1:0]                              cfg_addr_i,
  input  wire [pad_ctrl_pkg::WORD_W-1:0]                              cfg_wdata_i,
  input  wire                                                         wd_kick_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                              pad_in_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                              perio_out_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                              perio_oe_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                              apbio_out_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                              apbio_oe_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                              fpgaio_out_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                              fpgaio_oe_i,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                             pad_out_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                             pad_oe_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PADCFG_W-1:0] pad_cfg_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                             perio_in_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                             apbio_in_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                             fpgaio_in_o,
  output logic                                                        soc_rst_n_o,
  output logic                                                        bootsel_o,
  output logic                                                        wd_expired_o
);

  logic                                                     soc_rst_n;
  logic                                                     soc_clear;
  logic                                                     wd_expired;
  logic                                                     pad_we;
  logic [pad_ctrl_pkg::IDX_W-1:0]                           pad_idx;
  logic                                                     wd_load;
  logic                                                     wd_kick;
  pad_ctrl_pkg::cfg_word_u                                  wdata;
  logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::MUX_W-1:0] mux_sel;

  assign wdata = cfg_wdata_i;

  // Address decode gated by the soc reset
  assign pad_idx = cfg_addr_i[pad_ctrl_pkg::IDX_W-1:0];
  assign pad_we  = cfg_we_i && soc_rst_n
                   && (cfg_addr_i < pad_ctrl_pkg::ADDR_W'(pad_ctrl_pkg::N_PADS));
  assign wd_load = cfg_we_i && soc_rst_n && (cfg_addr_i == pad_ctrl_pkg::WD_ADDR);
  assign wd_kick = wd_kick_i && soc_rst_n;

  // Expiry clears on the same edge that drops the soc reset,
  // so pads are already released during the watchdog hold
  assign soc_clear = !soc_rst_n || wd_expired;

  reset_sequencer reset_sequencer_i (
    .io           (io),
    .arst_n_i     (arst_n_i),
    .wd_expired_i (wd_expired),
    .bootsel_i    (bootsel_i),
    .soc_rst_n_o  (soc_rst_n),
    .bootsel_o    (bootsel_o)
  );

  watchdog_timer watchdog_timer_i (
    .io        (io),
    .arst_n_i  (arst_n_i),
    .clear_i   (soc_clear),
    .load_i    (wd_load),
    .reload_i  (wdata.reload),
    .kick_i    (wd_kick),
    .expired_o (wd_expired)
  );

  pad_cfg_regs pad_cfg_regs_i (
    .io        (io),
    .arst_n_i  (arst_n_i),
    .clear_i   (soc_clear),
    .we_i      (pad_we),
    .idx_i     (pad_idx),
    .wdata_i   (wdata),
    .mux_sel_o (mux_sel),
    .pad_cfg_o (pad_cfg_o)
  );

  pad_mux pad_mux_i (
    .mux_sel_i    (mux_sel),
    .pad_in_i     (pad_in_i),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .apbio_out_i  (apbio_out_i),
    .apbio_oe_i   (apbio_oe_i),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .pad_out_o    (pad_out_o),
    .pad_oe_o     (pad_oe_o),
    .perio_in_o   (perio_in_o),
    .apbio_in_o   (apbio_in_o),
    .fpgaio_in_o  (fpgaio_in_o)
  );

  assign soc_rst_n_o  = soc_rst_n;
  assign wd_expired_o = wd_expired;

endmodule

`default_nettype wire

//--- verilog/pad_mux.sv
`timescale 1ns/1ps
`default_nettype none

module pad_mux (
  input  wire [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::MUX_W-1:0] mux_sel_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                          pad_in_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                          perio_out_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                          perio_oe_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                          apbio_out_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                          apbio_oe_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                          fpgaio_out_i,
  input  wire [pad_ctrl_pkg::N_PADS-1:0]                          fpgaio_oe_i,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                         pad_out_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                         pad_oe_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                         perio_in_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                         apbio_in_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0]                         fpgaio_in_o
);

  always_comb begin
    pad_out_o   = '0;
    pad_oe_o    = '0;
    perio_in_o  = '0;
    apbio_in_o  = '0;
    fpgaio_in_o = '0;
    for (int i = 0; i < pad_ctrl_pkg::N_PADS; i++) begin
      case (mux_sel_i[i])
        pad_ctrl_pkg::SEL_PERIO: begin
          pad_out_o[i]  = perio_out_i[i];
          pad_oe_o[i]   = perio_oe_i[i];
          perio_in_o[i] = pad_in_i[i];
        end
        pad_ctrl_pkg::SEL_APBIO: begin
          pad_out_o[i]  = apbio_out_i[i];
          pad_oe_o[i]   = apbio_oe_i[i];
          apbio_in_o[i] = pad_in_i[i];
        end
        pad_ctrl_pkg::SEL_FPGAIO: begin
          pad_out_o[i]   = fpgaio_out_i[i];
          pad_oe_o[i]    = fpgaio_oe_i[i];
          fpgaio_in_o[i] = pad_in_i[i];
        end
        // Unused pad stays tristated
        default: begin
          pad_out_o[i] = 1'b0;
          pad_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/pad_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pad_cfg_regs (
  input  wire                                                         io,
  input  wire                                                         arst_n_i,
  input  wire                                                         clear_i,
  input  wire                                                         we_i,
  input  wire [pad_ctrl_pkg::IDX_W-1:0]                               idx_i,
  input  wire pad_ctrl_pkg::cfg_word_u                                wdata_i,
  output logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::MUX_W-1:0]    mux_sel_o,
  output logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PADCFG_W-1:0] pad_cfg_o
);

  logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::MUX_W-1:0]    mux_sel_q;
  logic [pad_ctrl_pkg::N_PADS-1:0][pad_ctrl_pkg::PADCFG_W-1:0] pad_cfg_q;

  always_ff @(posedge io or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < pad_ctrl_pkg::N_PADS; i++) begin
        mux_sel_q[i] <= pad_ctrl_pkg::SEL_NONE;
        pad_cfg_q[i] <= pad_ctrl_pkg::PADCFG_DEFAULT;
      end
    end else if (clear_i) begin
      for (int i = 0; i < pad_ctrl_pkg::N_PADS; i++) begin
        mux_sel_q[i] <= pad_ctrl_pkg::SEL_NONE;
        pad_cfg_q[i] <= pad_ctrl_pkg::PADCFG_DEFAULT;
      end
    end else if (we_i) begin
      // Pad view of the write word
      mux_sel_q[idx_i] <= wdata_i.pad.mux_sel;
      pad_cfg_q[idx_i] <= wdata_i.pad.pad_cfg;
    end
  end

  assign mux_sel_o = mux_sel_q;
  assign pad_cfg_o = pad_cfg_q;

endmodule

`default_nettype wire

//--- verilog/watchdog_timer.sv
`timescale 1ns/1ps
`default_nettype none

module watchdog_timer (
  input  wire                            io,
  input  wire                            arst_n_i,
  input  wire                            clear_i,
  input  wire                            load_i,
  input  wire [pad_ctrl_pkg::WORD_W-1:0] reload_i,
  input  wire                            kick_i,
  output logic                           expired_o
);

  logic [pad_ctrl_pkg::WORD_W-1:0] reload_q;
  logic [pad_ctrl_pkg::WORD_W-1:0] count_q;
  logic                            en_q;
  logic                            expired_q;

  // Reload value restored by a kick
  always_ff @(posedge io or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reload_q <= '0;
    end else if (clear_i) begin
      reload_q <= '0;
    end else if (load_i) begin
      reload_q <= reload_i;
    end
  end

  always_ff @(posedge io or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q   <= '0;
      en_q      <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      expired_q <= 1'b0;
      if (clear_i) begin
        count_q <= '0;
        en_q    <= 1'b0;
      end else if (load_i) begin
        count_q <= reload_i;
        en_q    <= (reload_i != '0);
      end else if (kick_i && en_q) begin
        count_q <= reload_q;
      end else if (en_q) begin
        count_q <= count_q - 1'b1;
        // Fire once and stop on the last step of the count
        if (count_q == pad_ctrl_pkg::WORD_W'(1)) begin
          expired_q <= 1'b1;
          en_q      <= 1'b0;
        end
      end
    end
  end

  assign expired_o = expired_q;

endmodule

`default_nettype wire

//--- verilog/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
  input  wire  io,
  input  wire  arst_n_i,
  input  wire  wd_expired_i,
  input  wire  bootsel_i,
  output logic soc_rst_n_o,
  output logic bootsel_o
);

  logic [1:0]                      state_q;
  logic [1:0]                      state_d;
  logic [pad_ctrl_pkg::HOLD_W-1:0] cnt_q;
  logic                            hold_done;
  logic                            bootsel_q;

  assign hold_done = (cnt_q == pad_ctrl_pkg::HOLD_W'(pad_ctrl_pkg::RST_HOLD - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      pad_ctrl_pkg::ST_HOLD,
      pad_ctrl_pkg::ST_WD_HOLD: begin
        if (hold_done) begin
          state_d = pad_ctrl_pkg::ST_RUN;
        end
      end
      pad_ctrl_pkg::ST_RUN: begin
        // Watchdog expiry re-applies the soc reset
        if (wd_expired_i) begin
          state_d = pad_ctrl_pkg::ST_WD_HOLD;
        end
      end
      default: begin
        state_d = pad_ctrl_pkg::ST_HOLD;
      end
    endcase
  end

  always_ff @(posedge io or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= pad_ctrl_pkg::ST_HOLD;
      cnt_q     <= '0;
      bootsel_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Counter idles at zero while running
      if (state_q == pad_ctrl_pkg::ST_RUN || hold_done) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Sample boot pin on the release edge
      if (state_q != pad_ctrl_pkg::ST_RUN && state_d == pad_ctrl_pkg::ST_RUN) begin
        bootsel_q <= bootsel_i;
      end
    end
  end

  assign soc_rst_n_o = (state_q == pad_ctrl_pkg::ST_RUN);
  assign bootsel_o   = bootsel_q;

endmodule

`default_nettype wire

//--- verilog/pad_ctrl_pkg.sv
`default_nettype none

package pad_ctrl_pkg;

  // Pad array and register sizes
  localparam int N_PADS   = 8;
  localparam int IDX_W    = $clog2(N_PADS);
  localparam int MUX_W    = 2;
  localparam int PADCFG_W = 6;
  localparam int WORD_W   = 16;
  localparam int ADDR_W   = 4;

  // Internal reset hold time in cycles
  localparam int RST_HOLD = 4;
  localparam int HOLD_W   = $clog2(RST_HOLD + 1);

  // Pad mux select codes
  localparam logic [MUX_W-1:0] SEL_PERIO  = 2'd0;
  localparam logic [MUX_W-1:0] SEL_APBIO  = 2'd1;
  localparam logic [MUX_W-1:0] SEL_FPGAIO = 2'd2;
  localparam logic [MUX_W-1:0] SEL_NONE   = 2'd3;

  localparam logic [PADCFG_W-1:0] PADCFG_DEFAULT = '0;

  // Watchdog reload sits right above the pads
  localparam logic [ADDR_W-1:0] WD_ADDR = 4'd8;

  // Reset sequencer states
  localparam logic [1:0] ST_HOLD    = 2'd0;
  localparam logic [1:0] ST_RUN     = 2'd1;
  localparam logic [1:0] ST_WD_HOLD = 2'd2;

  // One write word read as pad settings or as watchdog reload
  typedef union packed {
    struct packed {
      logic [WORD_W-MUX_W-PADCFG_W-1:0] rsvd;
      logic [MUX_W-1:0]                 mux_sel;
      logic [PADCFG_W-1:0]              pad_cfg;
    } pad;
    logic [WORD_W-1:0] reload;
  } cfg_word_u;

endpackage

`default_nettype wire
